// ==== rv_isa_pkg.sv ====
/*
 * RV32I base opcodes, ALU and branch funct3 codes, core FSM states
 */
package rv_isa_pkg;

  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,  // register-immediate ALU
    op_reg    = 7'b0110011   // register-register ALU
  } opcode_e;

  typedef enum logic [2:0] {
    f3_add_sub = 3'b000,
    f3_sll     = 3'b001,
    f3_slt     = 3'b010,
    f3_sltu    = 3'b011,
    f3_xor     = 3'b100,
    f3_srl_sra = 3'b101,  // ir[30] picks arithmetic
    f3_or      = 3'b110,
    f3_and     = 3'b111
  } alu_funct3_e;

  typedef enum logic [2:0] {
    f3_beq  = 3'b000,
    f3_bne  = 3'b001,
    f3_blt  = 3'b100,
    f3_bge  = 3'b101,
    f3_bltu = 3'b110,
    f3_bgeu = 3'b111
  } branch_funct3_e;

  typedef enum logic [2:0] {
    cs_wait_boot,
    cs_fetch,
    cs_execute,
    cs_store,
    cs_load,
    cs_load_done
  } core_state_e;

endpackage

// ==== soc_mem_pkg.sv ====
/*
 * RAM access types, flash loader states and the led register address
 */
package soc_mem_pkg;

  typedef enum logic [1:0] {
    wt_none = 2'b00,
    wt_byte = 2'b01,
    wt_half = 2'b10,
    wt_word = 2'b11
  } write_type_e;

  // bit 2 requests sign extension, bits 1:0 the size
  typedef enum logic [2:0] {
    rt_none        = 3'b000,
    rt_byte        = 3'b001,
    rt_half        = 3'b010,
    rt_word        = 3'b011,
    rt_byte_signed = 3'b101,
    rt_half_signed = 3'b110,
    rt_word_signed = 3'b111
  } read_type_e;

  typedef enum logic [2:0] {
    ld_power_wait,
    ld_load_cmd,
    ld_send,
    ld_load_addr,
    ld_read_data,
    ld_start_write,
    ld_write,
    ld_done
  } loader_state_e;

  localparam logic [31:0] LED_ADDR = 32'hFFFF_FFF0;

endpackage

// ==== flash_loader.sv ====
/*
 * SPI flash boot loader: read command, little-endian word assembly
 * and word writes into RAM, then boot_done
 */
`timescale 1ns/10ps

module flash_loader #(
  parameter int STARTUP_WAIT = 1000,
  parameter int BOOT_BYTES   = 64
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        flash_miso,
  input  logic        busy,
  output logic        flash_clk,
  output logic        flash_mosi,
  output logic        flash_cs,
  output logic        boot_enable,
  output logic [31:0] boot_address,
  output logic [31:0] boot_data,
  output logic        boot_done
);

  soc_mem_pkg::loader_state_e state;
  soc_mem_pkg::loader_state_e return_state;  // where the sender goes when done
  logic [31:0] wait_cnt;
  logic [23:0] shift_out;
  logic [4:0]  bits_left;
  logic [3:0]  bit_cnt;     // bit 0 is the flash_clk phase
  logic [7:0]  byte_in;
  logic [1:0]  byte_num;
  logic [31:0] word_in;
  logic [31:0] next_address;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= soc_mem_pkg::ld_power_wait;
      return_state <= soc_mem_pkg::ld_power_wait;
      wait_cnt     <= '0;
      shift_out    <= '0;
      bits_left    <= '0;
      bit_cnt      <= '0;
      byte_in      <= '0;
      byte_num     <= '0;
      word_in      <= '0;
      next_address <= '0;
      flash_clk    <= 1'b0;
      flash_mosi   <= 1'b0;
      flash_cs     <= 1'b1;
      boot_enable  <= 1'b0;
      boot_address <= '0;
      boot_data    <= '0;
      boot_done    <= 1'b0;
    end else begin
      case (state)
        soc_mem_pkg::ld_power_wait: begin
          wait_cnt <= wait_cnt + 1'b1;
          if (wait_cnt == 32'(STARTUP_WAIT)) state <= soc_mem_pkg::ld_load_cmd;
        end
        soc_mem_pkg::ld_load_cmd: begin
          flash_cs     <= 1'b0;
          shift_out    <= {8'd3, 16'd0};  // read command
          bits_left    <= 5'd8;
          return_state <= soc_mem_pkg::ld_load_addr;
          state        <= soc_mem_pkg::ld_send;
        end
        soc_mem_pkg::ld_load_addr: begin
          shift_out    <= 24'd0;  // start address
          bits_left    <= 5'd24;
          byte_num     <= 2'd0;
          return_state <= soc_mem_pkg::ld_read_data;
          state        <= soc_mem_pkg::ld_send;
        end
        soc_mem_pkg::ld_send: begin
          // two ticks per bit, so bit_cnt is back at zero afterwards
          bit_cnt <= bit_cnt + 1'b1;
          if (!bit_cnt[0]) begin
            flash_clk  <= 1'b0;
            flash_mosi <= shift_out[23];  // msb first
            shift_out  <= {shift_out[22:0], 1'b0};
            bits_left  <= bits_left - 1'b1;
          end else begin
            flash_clk <= 1'b1;
            if (bits_left == 5'd0) state <= return_state;
          end
        end
        soc_mem_pkg::ld_read_data: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (!bit_cnt[0]) begin
            flash_clk <= 1'b0;
          end else begin
            flash_clk <= 1'b1;
            byte_in   <= {byte_in[6:0], flash_miso};
            if (bit_cnt == 4'd15) begin
              // newest byte enters at the top, first byte ends in [7:0]
              word_in  <= {byte_in[6:0], flash_miso, word_in[31:8]};
              byte_num <= byte_num + 1'b1;
              if (byte_num == 2'd3) state <= soc_mem_pkg::ld_start_write;
            end
          end
        end
        soc_mem_pkg::ld_start_write: begin
          if (!busy) begin
            boot_enable  <= 1'b1;
            boot_address <= next_address;
            boot_data    <= word_in;
            next_address <= next_address + 32'd4;
            state        <= soc_mem_pkg::ld_write;
          end
        end
        soc_mem_pkg::ld_write: begin
          boot_enable <= 1'b0;  // one request only
          if (!busy && !boot_enable) begin
            if (next_address < 32'(BOOT_BYTES)) begin
              state <= soc_mem_pkg::ld_read_data;
            end else begin
              flash_cs  <= 1'b1;
              boot_done <= 1'b1;
              state     <= soc_mem_pkg::ld_done;
            end
          end
        end
        default: ;  // ld_done, parked
      endcase
    end
  end

endmodule

// ==== rv_core.sv ====
/*
 * multi-cycle RV32I core: fetch, decode, ALU, branches and jumps,
 * sized load and store requests toward ram_io
 */
`timescale 1ns/10ps

module rv_core (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        boot_done,
  input  logic [31:0] data_out,
  input  logic        data_out_ready,
  input  logic        busy,
  input  logic [31:0] rs1_dat,
  input  logic [31:0] rs2_dat,
  output logic        core_enable,
  output logic [2:0]  core_read_type,
  output logic [1:0]  core_write_type,
  output logic [31:0] core_address,
  output logic [31:0] core_data_in,
  output logic [4:0]  rs1,
  output logic [4:0]  rs2,
  output logic [4:0]  rd,
  output logic [31:0] rd_wd,
  output logic        rd_we
);

  rv_isa_pkg::core_state_e state;
  rv_isa_pkg::opcode_e     opcode;
  soc_mem_pkg::read_type_e  load_type;
  soc_mem_pkg::write_type_e store_type;
  logic [31:0] pc;
  logic [31:0] ir;
  logic [2:0]  funct3;
  logic [31:0] u_imm;
  logic [31:0] i_imm;
  logic [31:0] s_imm;
  logic [31:0] b_imm;
  logic [31:0] j_imm;
  logic [31:0] pc_plus4;
  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic        take_branch;

  assign opcode   = rv_isa_pkg::opcode_e'(ir[6:0]);
  assign funct3   = ir[14:12];
  assign rd       = ir[11:7];
  assign rs1      = ir[19:15];
  assign rs2      = ir[24:20];
  assign u_imm    = {ir[31:12], 12'd0};
  assign i_imm    = {{20{ir[31]}}, ir[31:20]};
  assign s_imm    = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign b_imm    = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
  assign j_imm    = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
  assign pc_plus4 = pc + 32'd4;
  // immediate forms take the shift amount from i_imm[4:0]
  assign alu_b    = (opcode == rv_isa_pkg::op_reg) ? rs2_dat : i_imm;

  always_comb begin
    case (rv_isa_pkg::alu_funct3_e'(funct3))
      rv_isa_pkg::f3_add_sub: begin
        if (opcode == rv_isa_pkg::op_reg && ir[30]) alu_result = rs1_dat - alu_b;
        else alu_result = rs1_dat + alu_b;
      end
      rv_isa_pkg::f3_sll:  alu_result = rs1_dat << alu_b[4:0];
      rv_isa_pkg::f3_slt:  alu_result = {31'd0, $signed(rs1_dat) < $signed(alu_b)};
      rv_isa_pkg::f3_sltu: alu_result = {31'd0, rs1_dat < alu_b};
      rv_isa_pkg::f3_xor:  alu_result = rs1_dat ^ alu_b;
      rv_isa_pkg::f3_srl_sra: begin
        if (ir[30]) alu_result = $signed(rs1_dat) >>> alu_b[4:0];
        else alu_result = rs1_dat >> alu_b[4:0];
      end
      rv_isa_pkg::f3_or:   alu_result = rs1_dat | alu_b;
      default:             alu_result = rs1_dat & alu_b;
    endcase
  end

  always_comb begin
    case (rv_isa_pkg::branch_funct3_e'(funct3))
      rv_isa_pkg::f3_beq:  take_branch = rs1_dat == rs2_dat;
      rv_isa_pkg::f3_bne:  take_branch = rs1_dat != rs2_dat;
      rv_isa_pkg::f3_blt:  take_branch = $signed(rs1_dat) < $signed(rs2_dat);
      rv_isa_pkg::f3_bge:  take_branch = $signed(rs1_dat) >= $signed(rs2_dat);
      rv_isa_pkg::f3_bltu: take_branch = rs1_dat < rs2_dat;
      rv_isa_pkg::f3_bgeu: take_branch = rs1_dat >= rs2_dat;
      default:             take_branch = 1'b0;
    endcase
  end

  // load/store funct3 to ram_io access types
  always_comb begin
    case (funct3)
      3'b000:  load_type = soc_mem_pkg::rt_byte_signed;  // lb
      3'b001:  load_type = soc_mem_pkg::rt_half_signed;  // lh
      3'b010:  load_type = soc_mem_pkg::rt_word_signed;  // lw
      3'b100:  load_type = soc_mem_pkg::rt_byte;         // lbu
      3'b101:  load_type = soc_mem_pkg::rt_half;         // lhu
      default: load_type = soc_mem_pkg::rt_none;
    endcase
    case (funct3)
      3'b000:  store_type = soc_mem_pkg::wt_byte;
      3'b001:  store_type = soc_mem_pkg::wt_half;
      3'b010:  store_type = soc_mem_pkg::wt_word;
      default: store_type = soc_mem_pkg::wt_none;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state           <= rv_isa_pkg::cs_wait_boot;
      pc              <= '0;
      ir              <= '0;
      core_enable     <= 1'b0;
      core_read_type  <= soc_mem_pkg::rt_none;
      core_write_type <= soc_mem_pkg::wt_none;
      core_address    <= '0;
      core_data_in    <= '0;
      rd_wd           <= '0;
      rd_we           <= 1'b0;
    end else begin
      core_enable <= 1'b0;  // requests last one cycle
      rd_we       <= 1'b0;
      case (state)
        rv_isa_pkg::cs_wait_boot: begin
          if (boot_done) begin
            core_enable     <= 1'b1;
            core_read_type  <= soc_mem_pkg::rt_word;
            core_write_type <= soc_mem_pkg::wt_none;
            core_address    <= '0;
            state           <= rv_isa_pkg::cs_fetch;
          end
        end
        rv_isa_pkg::cs_fetch: begin
          if (data_out_ready) begin
            ir    <= data_out;
            state <= rv_isa_pkg::cs_execute;
          end
        end
        rv_isa_pkg::cs_execute: begin
          // default is a fetch of the next sequential instruction
          core_enable     <= 1'b1;
          core_read_type  <= soc_mem_pkg::rt_word;
          core_write_type <= soc_mem_pkg::wt_none;
          core_address    <= pc_plus4;
          pc              <= pc_plus4;
          state           <= rv_isa_pkg::cs_fetch;
          case (opcode)
            rv_isa_pkg::op_lui: begin
              rd_wd <= u_imm;
              rd_we <= 1'b1;
            end
            rv_isa_pkg::op_auipc: begin
              rd_wd <= pc + u_imm;
              rd_we <= 1'b1;
            end
            rv_isa_pkg::op_imm, rv_isa_pkg::op_reg: begin
              rd_wd <= alu_result;
              rd_we <= 1'b1;
            end
            rv_isa_pkg::op_jal: begin
              rd_wd        <= pc_plus4;
              rd_we        <= 1'b1;
              core_address <= pc + j_imm;
              pc           <= pc + j_imm;
            end
            rv_isa_pkg::op_jalr: begin
              rd_wd        <= pc_plus4;
              rd_we        <= 1'b1;
              core_address <= (rs1_dat + i_imm) & ~32'd1;
              pc           <= (rs1_dat + i_imm) & ~32'd1;
            end
            rv_isa_pkg::op_branch: begin
              if (take_branch) begin
                core_address <= pc + b_imm;
                pc           <= pc + b_imm;
              end
            end
            rv_isa_pkg::op_store: begin
              core_read_type  <= soc_mem_pkg::rt_none;
              core_write_type <= store_type;
              core_address    <= rs1_dat + s_imm;
              core_data_in    <= rs2_dat;  // ram_io picks the lane
              state           <= rv_isa_pkg::cs_store;
            end
            rv_isa_pkg::op_load: begin
              core_read_type <= load_type;
              core_address   <= rs1_dat + i_imm;
              state          <= rv_isa_pkg::cs_load;
            end
            default: ;  // unsupported, skipped
          endcase
        end
        rv_isa_pkg::cs_store: begin
          // first cycle still has the request out, busy follows
          if (!busy && !core_enable) begin
            core_enable     <= 1'b1;
            core_read_type  <= soc_mem_pkg::rt_word;
            core_write_type <= soc_mem_pkg::wt_none;
            core_address    <= pc;
            state           <= rv_isa_pkg::cs_fetch;
          end
        end
        rv_isa_pkg::cs_load: begin
          if (data_out_ready) begin
            rd_wd <= data_out;  // already extended
            rd_we <= 1'b1;
            state <= rv_isa_pkg::cs_load_done;
          end
        end
        default: begin  // cs_load_done
          core_enable     <= 1'b1;
          core_read_type  <= soc_mem_pkg::rt_word;
          core_write_type <= soc_mem_pkg::wt_none;
          core_address    <= pc;
          state           <= rv_isa_pkg::cs_fetch;
        end
      endcase
    end
  end

endmodule

// ==== register_file.sv ====
/*
 * 32 x 32 register file, combinational reads, x0 reads zero
 */
`timescale 1ns/10ps

module register_file (
  input  logic        clk,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic [31:0] rd_wd,
  input  logic        rd_we,
  output logic [31:0] rs1_dat,
  output logic [31:0] rs2_dat
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (rd_we && rd != 5'd0) regs[rd] <= rd_wd;  // x0 writes dropped
  end

  assign rs1_dat = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rs2_dat = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

// ==== ram_io.sv ====
/*
 * byte-lane RAM shared by loader and core, sized sign-aware reads,
 * memory-mapped led register
 */
`timescale 1ns/10ps

module ram_io #(
  parameter int RAM_WORDS = 256
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        boot_enable,
  input  logic [31:0] boot_address,
  input  logic [31:0] boot_data,
  input  logic        core_enable,
  input  logic [2:0]  core_read_type,
  input  logic [1:0]  core_write_type,
  input  logic [31:0] core_address,
  input  logic [31:0] core_data_in,
  output logic [31:0] data_out,
  output logic        data_out_ready,
  output logic        busy,
  output logic [7:0]  led
);

  localparam int AW = $clog2(RAM_WORDS);

  logic [31:0]   mem [RAM_WORDS];
  logic [31:0]   address;
  logic [31:0]   wr_data;
  logic [1:0]    write_type;
  logic [2:0]    read_type;
  logic          accept;
  logic          is_write;
  logic [3:0]    byte_en;
  logic [31:0]   lane_data;
  logic [AW-1:0] word_idx;
  logic [31:0]   read_word;
  logic [31:0]   shifted;
  logic [2:0]    rd_type_q;
  logic [1:0]    rd_off_q;

  // requesters never overlap, the loader only writes words
  assign address    = boot_enable ? boot_address : core_address;
  assign wr_data    = boot_enable ? boot_data : core_data_in;
  assign write_type = boot_enable ? soc_mem_pkg::wt_word : core_write_type;
  assign read_type  = boot_enable ? soc_mem_pkg::rt_none : core_read_type;
  assign accept     = (boot_enable || core_enable) && !busy;
  assign is_write   = write_type != soc_mem_pkg::wt_none;
  assign word_idx   = address[AW+1:2];

  always_comb begin
    case (soc_mem_pkg::write_type_e'(write_type))
      soc_mem_pkg::wt_byte: begin
        byte_en   = 4'b0001 << address[1:0];
        lane_data = {4{wr_data[7:0]}};
      end
      soc_mem_pkg::wt_half: begin
        byte_en   = address[1] ? 4'b1100 : 4'b0011;
        lane_data = {2{wr_data[15:0]}};
      end
      soc_mem_pkg::wt_word: begin
        byte_en   = 4'b1111;
        lane_data = wr_data;
      end
      default: begin
        byte_en   = 4'b0000;
        lane_data = wr_data;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept && address != soc_mem_pkg::LED_ADDR) begin
      for (int i = 0; i < 4; i++) begin
        if (byte_en[i]) mem[word_idx][8*i +: 8] <= lane_data[8*i +: 8];
      end
      read_word <= mem[word_idx];  // old contents on a write
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy           <= 1'b0;
      data_out_ready <= 1'b0;
      rd_type_q      <= soc_mem_pkg::rt_none;
      rd_off_q       <= 2'd0;
      led            <= 8'd0;
    end else begin
      busy           <= accept && is_write;  // one cycle per write
      data_out_ready <= accept && read_type != soc_mem_pkg::rt_none;
      if (accept) begin
        rd_type_q <= read_type;
        rd_off_q  <= address[1:0];
      end
      if (accept && is_write && address == soc_mem_pkg::LED_ADDR) led <= wr_data[7:0];
    end
  end

  assign shifted = read_word >> {rd_off_q, 3'b000};

  always_comb begin
    case (soc_mem_pkg::read_type_e'(rd_type_q))
      soc_mem_pkg::rt_byte:        data_out = {24'd0, shifted[7:0]};
      soc_mem_pkg::rt_byte_signed: data_out = {{24{shifted[7]}}, shifted[7:0]};
      soc_mem_pkg::rt_half:        data_out = {16'd0, shifted[15:0]};
      soc_mem_pkg::rt_half_signed: data_out = {{16{shifted[15]}}, shifted[15:0]};
      default:                     data_out = read_word;
    endcase
  end

endmodule

// ==== rv_soc.sv ====
/*
 * SoC top: flash loader, RV32I core, register file, RAM with led port
 */
`timescale 1ns/10ps

module rv_soc #(
  parameter int STARTUP_WAIT = 1000,
  parameter int BOOT_BYTES   = 64,
  parameter int RAM_WORDS    = 256
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       flash_miso,
  output logic       flash_clk,
  output logic       flash_mosi,
  output logic       flash_cs,
  output logic [7:0] led
);

  logic        boot_enable;
  logic [31:0] boot_address;
  logic [31:0] boot_data;
  logic        boot_done;
  logic        core_enable;
  logic [2:0]  core_read_type;
  logic [1:0]  core_write_type;
  logic [31:0] core_address;
  logic [31:0] core_data_in;
  logic [31:0] data_out;
  logic        data_out_ready;
  logic        busy;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  logic [31:0] rd_wd;
  logic        rd_we;
  logic [31:0] rs1_dat;
  logic [31:0] rs2_dat;

  flash_loader #(
    .STARTUP_WAIT(STARTUP_WAIT),
    .BOOT_BYTES  (BOOT_BYTES)
  ) u_flash_loader (
    .clk         (clk),
    .rst_n       (rst_n),
    .flash_miso  (flash_miso),
    .busy        (busy),
    .flash_clk   (flash_clk),
    .flash_mosi  (flash_mosi),
    .flash_cs    (flash_cs),
    .boot_enable (boot_enable),
    .boot_address(boot_address),
    .boot_data   (boot_data),
    .boot_done   (boot_done)
  );

  rv_core u_rv_core (
    .clk            (clk),
    .rst_n          (rst_n),
    .boot_done      (boot_done),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .busy           (busy),
    .rs1_dat        (rs1_dat),
    .rs2_dat        (rs2_dat),
    .core_enable    (core_enable),
    .core_read_type (core_read_type),
    .core_write_type(core_write_type),
    .core_address   (core_address),
    .core_data_in   (core_data_in),
    .rs1            (rs1),
    .rs2            (rs2),
    .rd             (rd),
    .rd_wd          (rd_wd),
    .rd_we          (rd_we)
  );

  register_file u_register_file (
    .clk    (clk),
    .rs1    (rs1),
    .rs2    (rs2),
    .rd     (rd),
    .rd_wd  (rd_wd),
    .rd_we  (rd_we),
    .rs1_dat(rs1_dat),
    .rs2_dat(rs2_dat)
  );

  ram_io #(
    .RAM_WORDS(RAM_WORDS)
  ) u_ram_io (
    .clk            (clk),
    .rst_n          (rst_n),
    .boot_enable    (boot_enable),
    .boot_address   (boot_address),
    .boot_data      (boot_data),
    .core_enable    (core_enable),
    .core_read_type (core_read_type),
    .core_write_type(core_write_type),
    .core_address   (core_address),
    .core_data_in   (core_data_in),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .busy           (busy),
    .led            (led)
  );

endmodule

// ==== rv_soc_properties.sv ====
/*
 * concurrent checks on the flash boot sequence and the ram_io strobes,
 * bound into rv_soc
 */
`timescale 1ns/10ps

module rv_soc_properties #(
  parameter int STARTUP_WAIT = 20,
  parameter int BOOT_BYTES   = 64
) (
  input logic       clk,
  input logic       rst_n,
  input logic       boot_enable,
  input logic       core_enable,
  input logic [2:0] core_read_type,
  input logic [1:0] core_write_type,
  input logic       busy,
  input logic       data_out_ready,
  input logic       flash_cs,
  input logic       flash_clk,
  input logic       boot_done
);

  int          fail_count = 0;  // read by the testbench at the end
  int unsigned cyc;             // cycles since reset release
  int unsigned clk_rises;       // rising flash_clk edges with cs low
  logic        fclk_q;
  logic        write_req;
  logic        read_req;

  assign write_req = (boot_enable || (core_enable && core_write_type != 2'd0)) && !busy;
  assign read_req  = core_enable && !boot_enable && core_read_type != 3'd0 && !busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc       <= 0;
      clk_rises <= 0;
      fclk_q    <= 1'b0;
    end else begin
      cyc    <= cyc + 1;
      fclk_q <= flash_clk;
      if (flash_clk && !fclk_q && !flash_cs) clk_rises <= clk_rises + 1;
    end
  end

  enables_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(boot_enable && core_enable))
    else begin fail_count++; $error("boot and core enables high together"); end

  write_busy_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    write_req |=> busy ##1 !busy)
    else begin fail_count++; $error("busy not high for exactly one cycle after write"); end

  read_ready_next: assert property (@(posedge clk) disable iff (!rst_n)
    read_req |=> data_out_ready)
    else begin fail_count++; $error("data_out_ready missing after read request"); end

  ready_has_request: assert property (@(posedge clk) disable iff (!rst_n)
    data_out_ready |-> $past(read_req))
    else begin fail_count++; $error("data_out_ready without a read one cycle before"); end

  cs_high_at_startup: assert property (@(posedge clk) disable iff (!rst_n)
    (cyc < STARTUP_WAIT) |-> flash_cs)
    else begin fail_count++; $error("flash_cs low before the startup wait ended"); end

  // 32 command and address bits, then 8 per image byte
  boot_length: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(flash_cs) |-> clk_rises == 32 + 8 * BOOT_BYTES)
    else begin fail_count++; $error("flash_cs released after wrong number of clocks"); end

  cs_stays_high: assert property (@(posedge clk) disable iff (!rst_n)
    boot_done |-> flash_cs)
    else begin fail_count++; $error("flash_cs low after boot_done"); end

  done_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    boot_done |=> boot_done)
    else begin fail_count++; $error("boot_done dropped"); end

endmodule

bind rv_soc rv_soc_properties #(
  .STARTUP_WAIT(STARTUP_WAIT),
  .BOOT_BYTES  (BOOT_BYTES)
) u_props (
  .clk            (clk),
  .rst_n          (rst_n),
  .boot_enable    (boot_enable),
  .core_enable    (core_enable),
  .core_read_type (core_read_type),
  .core_write_type(core_write_type),
  .busy           (busy),
  .data_out_ready (data_out_ready),
  .flash_cs       (flash_cs),
  .flash_clk      (flash_clk),
  .boot_done      (boot_done)
);

// ==== tb_rv_soc.sv ====
/*
 * testbench for rv_soc: clock, reset, SPI flash model with the boot
 * program, led update checks, timeout and closing report
 */
`timescale 1ns/10ps

module tb_rv_soc;

  localparam int STARTUP_WAIT = 20;
  localparam int BOOT_BYTES   = 64;
  localparam int RAM_WORDS    = 256;
  localparam int N_WORDS      = BOOT_BYTES / 4;
  localparam int CYCLE_LIMIT  = STARTUP_WAIT + 64 * 20 + 2000;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       flash_miso;
  logic       flash_clk;
  logic       flash_mosi;
  logic       flash_cs;
  logic [7:0] led;

  logic [31:0] program_rom [N_WORDS];
  logic [7:0]  expected [$];
  logic [31:0] cmd_word = '0;
  logic        fclk_prev = 1'b0;
  logic [7:0]  led_prev = 8'd0;
  int          cmd_bits = 0;
  int          data_bits = 0;
  int          exp_idx = 0;
  int          errors = 0;
  int          cycles = 0;

  rv_soc #(
    .STARTUP_WAIT(STARTUP_WAIT),
    .BOOT_BYTES  (BOOT_BYTES),
    .RAM_WORDS   (RAM_WORDS)
  ) dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .flash_miso(flash_miso),
    .flash_clk (flash_clk),
    .flash_mosi(flash_mosi),
    .flash_cs  (flash_cs),
    .led       (led)
  );

  always #10 clk = ~clk;

  always @(posedge clk) cycles <= cycles + 1;

  task automatic load_program();
    program_rom[0]  = 32'hFF00_0F93;  // addi x31, x0, -16   led address
    program_rom[1]  = 32'hF800_0093;  // addi x1, x0, -128
    program_rom[2]  = 32'h0410_1023;  // sh   x1, 64(x0)
    program_rom[3]  = 32'h0400_0103;  // lb   x2, 64(x0)
    program_rom[4]  = 32'h0400_5183;  // lhu  x3, 64(x0)
    program_rom[5]  = 32'h4041_5213;  // srai x4, x2, 4
    program_rom[6]  = 32'h4032_02B3;  // sub  x5, x4, x3
    program_rom[7]  = 32'h005F_8023;  // sb   x5, 0(x31)
    program_rom[8]  = 32'h0030_0313;  // addi x6, x0, 3
    program_rom[9]  = 32'h006F_8023;  // sb   x6, 0(x31)     loop body
    program_rom[10] = 32'hFFF3_0313;  // addi x6, x6, -1
    program_rom[11] = 32'hFE03_1CE3;  // bne  x6, x0, -8
    program_rom[12] = 32'h00C0_046F;  // jal  x8, +12        skips 13 and 14
    program_rom[13] = 32'h001F_8023;  // sb   x1, 0(x31)     never reached
    program_rom[14] = 32'h008F_8023;  // sb   x8, 0(x31)     return target
    program_rom[15] = 32'h0044_0067;  // jalr x0, 4(x8)      back to 14, spins there
  endtask

  // led values worked out from RV32I semantics of the program above
  task automatic build_expected();
    logic [31:0] v1;
    logic [31:0] lb_val;
    logic [31:0] lhu_val;
    logic [31:0] sra_val;
    logic [31:0] diff;
    logic [31:0] link;
    v1      = {{20{1'b1}}, 12'hF80};
    lb_val  = {{24{v1[7]}}, v1[7:0]};
    lhu_val = {16'd0, v1[15:0]};
    sra_val = $signed(lb_val) >>> 4;
    diff    = sra_val - lhu_val;
    expected.push_back(diff[7:0]);
    for (int c = 3; c > 0; c--) expected.push_back(8'(c));
    link = 32'd12 * 4 + 32'd4;  // return address of the jal
    expected.push_back(link[7:0]);
  endtask

  function automatic logic image_bit(int n);
    int          byte_idx;
    logic [31:0] word;
    logic [7:0]  byt;
    byte_idx = n / 8;
    if (byte_idx >= BOOT_BYTES) return 1'b0;
    word = program_rom[byte_idx / 4];
    byt  = 8'(word >> (8 * (byte_idx % 4)));  // little-endian within the word
    return byt[7 - (n % 8)];                  // msb first
  endfunction

  // flash model and led monitor, both on the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (!flash_cs && flash_clk && !fclk_prev) begin
        if (cmd_bits < 32) begin
          cmd_word = {cmd_word[30:0], flash_mosi};
          cmd_bits++;
          if (cmd_bits == 32) begin
            assert (cmd_word == 32'h0300_0000) else begin
              errors++;
              $display("ERR %0t flash_mosi expected %08h got %08h", $time, 32'h0300_0000,
                       cmd_word);
            end
          end
        end else begin
          data_bits++;
        end
      end
      fclk_prev = flash_clk;
      flash_miso <= image_bit(data_bits);
      if (led != led_prev) begin
        if (exp_idx < expected.size()) begin
          assert (led == expected[exp_idx]) else begin
            errors++;
            $display("ERR %0t led expected %02h got %02h", $time, expected[exp_idx], led);
          end
          exp_idx++;
        end else begin
          errors++;
          $display("led changed to %02h after the last expected update", led);
        end
        led_prev = led;
      end
    end
  end

  initial begin
    rst_n      = 1'b0;
    flash_miso = 1'b0;
    load_program();
    build_expected();
    repeat (10) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;
    while (exp_idx < expected.size() && cycles < CYCLE_LIMIT) @(negedge clk);
    if (cycles >= CYCLE_LIMIT) begin
      errors++;
      $display("timeout after %0d cycles, %0d of %0d led updates seen", cycles, exp_idx,
               expected.size());
    end else begin
      repeat (100) @(negedge clk);  // stray stores would show here
    end
    if (cmd_bits != 32) begin
      errors++;
      $display("flash saw %0d command bits instead of 32", cmd_bits);
    end
    $display("errors: testbench %0d, assertions %0d", errors, dut.u_props.fail_count);
    if (errors == 0 && dut.u_props.fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== rv_soc.f ====
rv_isa_pkg.sv
soc_mem_pkg.sv
flash_loader.sv
rv_core.sv
register_file.sv
ram_io.sv
rv_soc.sv
rv_soc_properties.sv
tb_rv_soc.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_rv_soc
FILELIST = rv_soc.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
